// ==== files.f ====
design/axi4s_err_pkg.sv
design/axi4s_pkt_discard_err.sv
design/axi4s_err_probe.sv
design/axi4s_err_regs.sv
design/axi4s_err_filter_top.sv
testbench/tb_axi4s_err_filter.sv

// ==== Bender.yml ====
package:
  name: axi4s_err_filter

sources:
  - design/axi4s_err_pkg.sv
  - design/axi4s_pkt_discard_err.sv
  - design/axi4s_err_probe.sv
  - design/axi4s_err_regs.sv
  - design/axi4s_err_filter_top.sv
  - target: test
    files:
      - testbench/tb_axi4s_err_filter.sv

// ==== testbench/tb_axi4s_err_filter.sv ====
//----------------------------------------------------------------------------
// random-stimulus testbench for the error-packet filter
// drives packets with gaps and stalls, checks every output beat against a
// reference model and reads the statistics counters over the register port
//----------------------------------------------------------------------------

`default_nettype none

module tb_axi4s_err_filter
   import axi4s_err_pkg::*;
;

   localparam int beat_timeout  = 64;
   localparam int rsp_timeout   = 8;
   localparam int drain_timeout = 32;

   logic       axi4s_in_if;
   logic       arst_n;
   logic       in_valid;
   axis_beat_t in_beat;
   logic       in_ready;
   logic       out_valid;
   axis_beat_t out_beat;
   logic       out_ready;
   reg_req_t   reg_req;
   reg_rsp_t   reg_rsp;

   // random source state
   logic [31:0] lfsr;

   // reference model state
   logic                m_sop;
   logic                m_err;
   logic [cnt_bits-1:0] m_pkts;
   logic [cnt_bits-1:0] m_bytes;
   axis_beat_t          exp_q[$];

   axi4s_err_filter_top i_axi4s_err_filter_top (
      .axi4s_in_if (axi4s_in_if),
      .arst_n      (arst_n),
      .in_valid    (in_valid),
      .in_beat     (in_beat),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .out_beat    (out_beat),
      .out_ready   (out_ready),
      .reg_req     (reg_req),
      .reg_rsp     (reg_rsp)
   );

   initial begin
      axi4s_in_if = 1'b0;
      forever begin
         #5 axi4s_in_if = ~axi4s_in_if;
      end
   end

   //-------------------------------------------------------------------------
   // random numbers and failure reporting
   //-------------------------------------------------------------------------

   // one step of a 32-bit Galois LFSR with a maximal-length polynomial
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // takes n random bits and steps the LFSR once for each
   task automatic take_bits(input int n, output logic [63:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val[i] = lfsr[0];
         lfsr    = lfsr_next(lfsr);
      end
   endtask

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic report_problem(input string msg);
      $display("error at %0t: %s", $time, msg);
      abort_run();
   endtask

   task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_rsp(input string name, input reg_rsp_t got, input reg_rsp_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_ready(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   //-------------------------------------------------------------------------
   // reference model that runs at the falling edge where everything is stable
   //-------------------------------------------------------------------------

   // judges the transfer that happens at the next rising edge
   task automatic observe_cycle();
      logic drop;
      drop = (m_sop && in_beat.tuser) || m_err;
      check_ready("in_ready", in_ready, out_ready);
      check_ready("out_valid", out_valid, in_valid && !drop);
      if (in_valid && in_ready) begin
         if (drop) begin
            m_bytes = m_bytes + cnt_bits'($countones(in_beat.tkeep));
            if (in_beat.tlast) begin
               m_pkts = m_pkts + 1'b1;
            end
         end else begin
            exp_q.push_back(in_beat);
         end
         // error state lasts until the tlast of the errored packet
         if (m_err && in_beat.tlast) begin
            m_err = 1'b0;
         end else if (m_sop && in_beat.tuser && !in_beat.tlast) begin
            m_err = 1'b1;
         end
         m_sop = in_beat.tlast;
      end
      if (out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            report_problem("an output beat transferred while no beat was expected");
         end
         check_beat("out_beat", out_beat, exp_q.pop_front());
      end
   endtask

   //-------------------------------------------------------------------------
   // stimulus
   //-------------------------------------------------------------------------

   // sends one packet of 1 to 8 beats with gaps before each beat and random stalls
   task automatic send_packet();
      logic [63:0] r;
      int          len;
      axis_beat_t  beat;
      logic        shown;
      logic        done;
      int          waited;
      take_bits(3, r);
      len = int'(r[2:0]) + 1;
      for (int i = 0; i < len; i++) begin
         take_bits(64, r);
         beat.tdata = r;
         take_bits(8, r);
         beat.tkeep = r[7:0];
         take_bits(4, r);
         beat.tid = r[3:0];
         take_bits(4, r);
         beat.tdest = r[3:0];
         beat.tlast = (i == len - 1);
         // the error flag hits about a quarter of the first beats
         if (i == 0) begin
            take_bits(2, r);
            beat.tuser = (r[1:0] == 2'd0);
         end else begin
            take_bits(1, r);
            beat.tuser = r[0];
         end
         shown  = 1'b0;
         done   = 1'b0;
         waited = 0;
         while (!done) begin
            if (waited == beat_timeout) begin
               report_problem("a stream beat was not accepted within the timeout");
            end
            @(posedge axi4s_in_if);
            #1;
            // once valid is up the beat is held until it transfers
            if (!shown) begin
               take_bits(2, r);
               shown = (r[1:0] != 2'd0);
            end
            in_valid = shown;
            in_beat  = beat;
            take_bits(2, r);
            out_ready = (r[1:0] != 2'd0);
            @(negedge axi4s_in_if);
            observe_cycle();
            done   = in_valid && in_ready;
            waited = waited + 1;
         end
      end
   endtask

   // idle the input until every expected beat has left the DUT
   task automatic drain_output();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == drain_timeout) begin
            report_problem("the expected output beats never came out of the DUT");
         end
         @(posedge axi4s_in_if);
         #1;
         in_valid  = 1'b0;
         out_ready = 1'b1;
         @(negedge axi4s_in_if);
         observe_cycle();
         waited = waited + 1;
      end
   endtask

   // one register request whose response must come exactly one cycle later
   task automatic reg_access(
      input logic                 write,
      input logic [addr_bits-1:0] addr,
      input logic [cnt_bits-1:0]  exp_data
   );
      reg_rsp_t exp_rsp;
      int       waited;
      exp_rsp.valid = 1'b1;
      exp_rsp.rdata = exp_data;
      waited        = 0;
      @(posedge axi4s_in_if);
      #1;
      in_valid      = 1'b0;
      reg_req.valid = 1'b1;
      reg_req.write = write;
      reg_req.addr  = addr;
      @(negedge axi4s_in_if);
      observe_cycle();
      while (!reg_rsp.valid) begin
         if (waited == rsp_timeout) begin
            report_problem("no register response arrived within the timeout");
         end
         @(posedge axi4s_in_if);
         #1;
         reg_req = '0;
         @(negedge axi4s_in_if);
         observe_cycle();
         waited = waited + 1;
      end
      if (waited != 1) begin
         report_problem($sformatf("register response came %0d cycles after the request", waited));
      end
      check_rsp("reg_rsp", reg_rsp, exp_rsp);
      // the response is a one-cycle pulse
      @(negedge axi4s_in_if);
      observe_cycle();
      check_ready("reg_rsp.valid", reg_rsp.valid, 1'b0);
   endtask

   //-------------------------------------------------------------------------
   // test sequence
   //-------------------------------------------------------------------------

   initial begin
      arst_n    = 1'b0;
      in_valid  = 1'b0;
      in_beat   = '0;
      out_ready = 1'b0;
      reg_req   = '0;
      lfsr      = 32'h8979_90f6;
      m_sop     = 1'b1;
      m_err     = 1'b0;
      m_pkts    = '0;
      m_bytes   = '0;
      repeat (3) @(posedge axi4s_in_if);
      #1;
      arst_n = 1'b1;

      // mixed good and errored traffic followed by a counter read
      for (int p = 0; p < 200; p++) begin
         send_packet();
      end
      drain_output();
      reg_access(1'b0, reg_addr_pkts, m_pkts);
      reg_access(1'b0, reg_addr_bytes, m_bytes);

      // clear both counters and see them read zero
      reg_access(1'b1, reg_addr_clear, '0);
      m_pkts  = '0;
      m_bytes = '0;
      reg_access(1'b0, reg_addr_pkts, '0);
      reg_access(1'b0, reg_addr_bytes, '0);

      // counting resumes from zero on new traffic
      for (int p = 0; p < 60; p++) begin
         send_packet();
      end
      drain_output();
      reg_access(1'b0, reg_addr_pkts, m_pkts);
      reg_access(1'b0, reg_addr_bytes, m_bytes);

      // unused addresses read back as zero
      reg_access(1'b0, 4'd12, '0);
      reg_access(1'b0, 4'd2, '0);

      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/axi4s_err_filter_top.sv ====
//----------------------------------------------------------------------------
// error-packet filter with statistics
// the stream path has zero latency and the counters sit behind a register port
//----------------------------------------------------------------------------

`default_nettype none

module axi4s_err_filter_top
   import axi4s_err_pkg::*;
(
   input  logic       axi4s_in_if,
   input  logic       arst_n,
   input  logic       in_valid,
   input  axis_beat_t in_beat,
   output logic       in_ready,
   output logic       out_valid,
   output axis_beat_t out_beat,
   input  logic       out_ready,
   input  reg_req_t   reg_req,
   output reg_rsp_t   reg_rsp
);

   // every transfer with tuser rewritten as the drop mark
   logic                probe_valid;
   axis_beat_t          probe_beat;
   logic                clear;
   logic [cnt_bits-1:0] pkt_count;
   logic [cnt_bits-1:0] byte_count;

   axi4s_pkt_discard_err i_axi4s_pkt_discard_err (
      .axi4s_in_if (axi4s_in_if),
      .arst_n      (arst_n),
      .in_valid    (in_valid),
      .in_beat     (in_beat),
      .in_ready    (in_ready),
      .out_valid   (out_valid),
      .out_beat    (out_beat),
      .out_ready   (out_ready),
      .probe_valid (probe_valid),
      .probe_beat  (probe_beat)
   );

   axi4s_err_probe i_axi4s_err_probe (
      .axi4s_in_if (axi4s_in_if),
      .arst_n      (arst_n),
      .probe_valid (probe_valid),
      .probe_beat  (probe_beat),
      .clear       (clear),
      .pkt_count   (pkt_count),
      .byte_count  (byte_count)
   );

   axi4s_err_regs i_axi4s_err_regs (
      .axi4s_in_if (axi4s_in_if),
      .arst_n      (arst_n),
      .reg_req     (reg_req),
      .reg_rsp     (reg_rsp),
      .pkt_count   (pkt_count),
      .byte_count  (byte_count),
      .clear       (clear)
   );

endmodule

`default_nettype wire

// ==== design/axi4s_err_regs.sv ====
//----------------------------------------------------------------------------
// register port for the error statistics
// one-beat requests, each answered exactly one cycle later
//----------------------------------------------------------------------------

`default_nettype none

module axi4s_err_regs
   import axi4s_err_pkg::*;
(
   input  logic                axi4s_in_if,
   input  logic                arst_n,
   input  reg_req_t            reg_req,
   output reg_rsp_t            reg_rsp,
   input  logic [cnt_bits-1:0] pkt_count,
   input  logic [cnt_bits-1:0] byte_count,
   output logic                clear
);

   logic                rsp_valid;
   logic [cnt_bits-1:0] rsp_rdata;
   // read data picked for the current request
   logic [cnt_bits-1:0] rd_sel;

   // writes and unknown addresses read back as zero
   always_comb begin
      rd_sel = '0;
      if (reg_req.valid && !reg_req.write) begin
         case (reg_req.addr)
            reg_addr_pkts:  rd_sel = pkt_count;
            reg_addr_bytes: rd_sel = byte_count;
            default:        rd_sel = '0;
         endcase
      end
   end

   //-------------------------------------------------------------------------
   // response and clear pulse
   //-------------------------------------------------------------------------

   // valid and clear are both one-cycle pulses
   // the counters read zero from the cycle after clear
   always_ff @(posedge axi4s_in_if or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid <= 1'b0;
         clear     <= 1'b0;
      end else begin
         rsp_valid <= reg_req.valid;
         clear     <= reg_req.valid && reg_req.write && (reg_req.addr == reg_addr_clear);
      end
   end

   // only meaningful while rsp_valid is high
   always_ff @(posedge axi4s_in_if) begin
      rsp_rdata <= rd_sel;
   end

   assign reg_rsp.valid = rsp_valid;
   assign reg_rsp.rdata = rsp_rdata;

endmodule

`default_nettype wire

// ==== design/axi4s_err_probe.sv ====
//----------------------------------------------------------------------------
// statistics for discarded traffic
// counts dropped packets and dropped bytes, both cleared by a one-cycle pulse
//----------------------------------------------------------------------------

`default_nettype none

module axi4s_err_probe
   import axi4s_err_pkg::*;
(
   input  logic                axi4s_in_if,
   input  logic                arst_n,
   input  logic                probe_valid,
   input  axis_beat_t          probe_beat,
   input  logic                clear,
   output logic [cnt_bits-1:0] pkt_count,
   output logic [cnt_bits-1:0] byte_count
);

   // wide enough to hold data_bytes itself
   localparam int keep_cnt_bits = $clog2(data_bytes + 1);

   // a transfer that the discard block dropped
   logic                     drop_xfer;
   // valid bytes in the dropped beat
   logic [keep_cnt_bits-1:0] keep_cnt;

   // number of set bits in a tkeep mask
   function automatic logic [keep_cnt_bits-1:0] keep_popcount(
      input logic [data_bytes-1:0] keep
   );
      logic [keep_cnt_bits-1:0] sum;
      sum = '0;
      for (int i = 0; i < data_bytes; i++) begin
         sum = sum + keep_cnt_bits'(keep[i]);
      end
      return sum;
   endfunction

   // tuser on the probe path already means "this beat was dropped"
   assign drop_xfer = probe_valid && probe_beat.tuser;
   assign keep_cnt  = keep_popcount(probe_beat.tkeep);

   //-------------------------------------------------------------------------
   // packet counter
   //-------------------------------------------------------------------------

   // one packet per dropped tlast beat
   // clear wins over a count in the same cycle
   always_ff @(posedge axi4s_in_if or negedge arst_n) begin
      if (!arst_n) begin
         pkt_count <= '0;
      end else if (clear) begin
         pkt_count <= '0;
      end else if (drop_xfer && probe_beat.tlast) begin
         pkt_count <= pkt_count + 1'b1;
      end
   end

   //-------------------------------------------------------------------------
   // byte counter
   //-------------------------------------------------------------------------

   // every dropped beat adds its tkeep population count
   // the sum simply wraps at cnt_bits
   always_ff @(posedge axi4s_in_if or negedge arst_n) begin
      if (!arst_n) begin
         byte_count <= '0;
      end else if (clear) begin
         byte_count <= '0;
      end else if (drop_xfer) begin
         byte_count <= byte_count + cnt_bits'(keep_cnt);
      end
   end

endmodule

`default_nettype wire

// ==== design/axi4s_pkt_discard_err.sv ====
//----------------------------------------------------------------------------
// zero-latency stream pass-through that removes whole errored packets
// a packet is errored when its first beat has tuser set
//----------------------------------------------------------------------------

`default_nettype none

module axi4s_pkt_discard_err
   import axi4s_err_pkg::*;
(
   input  logic       axi4s_in_if,
   input  logic       arst_n,
   input  logic       in_valid,
   input  axis_beat_t in_beat,
   output logic       in_ready,
   output logic       out_valid,
   output axis_beat_t out_beat,
   input  logic       out_ready,
   output logic       probe_valid,
   output axis_beat_t probe_beat
);

   // a beat moves on this edge
   logic xfer;
   // high while the next beat to arrive is the first of a packet
   logic sop;
   // first beat of a packet that carries the error flag and transfers now
   logic err_sop;
   // holds the error state over the rest of an errored packet
   logic err_pkt;
   // the current beat belongs to an errored packet
   logic drop;

   // back-pressure goes straight through, even while beats are discarded
   assign in_ready = out_ready;
   assign xfer     = in_valid && in_ready;

   //-------------------------------------------------------------------------
   // packet boundary tracking
   //-------------------------------------------------------------------------

   // the beat after a tlast starts a new packet
   always_ff @(posedge axi4s_in_if or negedge arst_n) begin
      if (!arst_n) begin
         sop <= 1'b1;
      end else if (xfer) begin
         sop <= in_beat.tlast;
      end
   end

   assign err_sop = xfer && sop && in_beat.tuser;

   // a one-beat errored packet ends on the beat that flags it
   // so err_pkt only rises when that first beat has no tlast
   always_ff @(posedge axi4s_in_if or negedge arst_n) begin
      if (!arst_n) begin
         err_pkt <= 1'b0;
      end else if (err_pkt && xfer && in_beat.tlast) begin
         err_pkt <= 1'b0;
      end else if (err_sop && !in_beat.tlast) begin
         err_pkt <= 1'b1;
      end
   end

   // the drop decision does not look at ready
   // on a transfer it equals err_sop or err_pkt, and out_valid stays free of out_ready
   assign drop = (sop && in_beat.tuser) || err_pkt;

   //-------------------------------------------------------------------------
   // output and probe
   //-------------------------------------------------------------------------

   assign out_valid = in_valid && !drop;
   assign out_beat  = in_beat;

   // the probe sees every transfer, with tuser marking the dropped ones
   assign probe_valid = xfer;
   always_comb begin
      probe_beat       = in_beat;
      probe_beat.tuser = drop;
   end

endmodule

`default_nettype wire

// ==== design/axi4s_err_pkg.sv ====
//----------------------------------------------------------------------------
// shared types and constants for the error-packet filter
// covers the stream beat layout, the register port and its address map
//----------------------------------------------------------------------------

`default_nettype none

package axi4s_err_pkg;

   //-------------------------------------------------------------------------
   // stream geometry
   //-------------------------------------------------------------------------

   // bytes carried by one beat, so tdata is eight times this wide
   localparam int data_bytes = 8;
   localparam int tid_bits   = 4;
   localparam int tdest_bits = 4;

   //-------------------------------------------------------------------------
   // statistics and register port
   //-------------------------------------------------------------------------

   // every counter wraps at this width
   localparam int cnt_bits  = 32;
   localparam int addr_bits = 4;

   // register map, one counter per 32-bit word
   localparam logic [addr_bits-1:0] reg_addr_pkts  = 4'd0;
   localparam logic [addr_bits-1:0] reg_addr_bytes = 4'd4;
   localparam logic [addr_bits-1:0] reg_addr_clear = 4'd8;

   // one stream beat
   // tuser is the error flag and only counts on the first beat of a packet
   typedef struct packed {
      logic [data_bytes*8-1:0] tdata;
      logic [data_bytes-1:0]   tkeep;
      logic [tid_bits-1:0]     tid;
      logic [tdest_bits-1:0]   tdest;
      logic                    tlast;
      logic                    tuser;
   } axis_beat_t;

   // a request lives for exactly one cycle while valid is high
   typedef struct packed {
      logic                 valid;
      logic                 write;
      logic [addr_bits-1:0] addr;
   } reg_req_t;

   // the response arrives one cycle after its request
   typedef struct packed {
      logic                valid;
      logic [cnt_bits-1:0] rdata;
   } reg_rsp_t;

endpackage

`default_nettype wire
